//--- rtl/audio_pkg.sv
package audio_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int SAMPLE_W   = 24;
    localparam int COEF_W     = 16;           // signed q1.15
    localparam int FRAC_W     = 15;           // fraction bits of coef and gain
    localparam int ACC_W      = 48;           // holds any product sum here
    localparam int NUM_BANDS  = 2;
    localparam int TAPS       = 4;
    localparam int SLOT_BITS  = 32;           // bit clocks per channel slot
    localparam int BAND_W     = $clog2(NUM_BANDS);
    localparam int TAP_W      = $clog2(TAPS);
    localparam int SLOT_W     = $clog2(SLOT_BITS);
    localparam int MAC_STEPS  = 2 * NUM_BANDS * TAPS;
    localparam int STEP_W     = $clog2(MAC_STEPS);
    localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

    // cpu register map
    localparam logic [2:0] REG_CTRL     = 3'd0;
    localparam logic [2:0] REG_SELECT   = 3'd1;
    localparam logic [2:0] REG_COEF_LSB = 3'd2;
    localparam logic [2:0] REG_COEF_MSB = 3'd3;
    localparam logic [2:0] REG_GAIN_LSB = 3'd4;
    localparam logic [2:0] REG_GAIN_MSB = 3'd5;
    localparam logic [2:0] REG_STATUS   = 3'd6;

    localparam int CTRL_FIR_BYPASS    = 0;
    localparam int CTRL_EQ_BYPASS     = 1;
    localparam int CTRL_ENABLE        = 2;
    localparam int STAT_COEF_PTR_ZERO = 0;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0]   coef_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic [BAND_W-1:0]          band_idx_t;
    typedef logic [TAP_W-1:0]           tap_idx_t;
    typedef sample_t [NUM_BANDS-1:0]    band_vec_t;   // one channel, all bands

    localparam coef_t GAIN_INIT = 16'sh7FFF;          // just under 1.0

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef struct packed {
        band_vec_t left;
        band_vec_t right;
    } stereo_bands_t;

    // clamp a wide sum into the pcm range
    function automatic sample_t sat_sample(input acc_t v);
        if (v > acc_t'(SAMPLE_MAX))
            return sample_t'(SAMPLE_MAX);
        else if (v < acc_t'(SAMPLE_MIN))
            return sample_t'(SAMPLE_MIN);
        return sample_t'(v);
    endfunction

endpackage

//--- rtl/pcm_if.sv
`timescale 1ns/1ps

// valid/ready sample stream, payload type set per instance
interface pcm_if #(
    parameter type T = logic
);
    logic valid;    // payload on data
    logic ready;    // sink takes it this edge
    T     data;
    logic first;    // first pair since enable

    modport source (
        output valid,
        output data,
        output first,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  first,
        output ready
    );

endinterface

//--- rtl/wb_audio_regs.sv
`timescale 1ns/1ps

module wb_audio_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    input  logic [7:0]           wb_dat_i,
    output logic [7:0]           wb_dat_o,
    output logic                 wb_ack,
    output logic                 fir_bypass,
    output logic                 eq_bypass,
    output logic                 enable,
    output audio_pkg::band_idx_t band_sel,
    output logic                 coef_we,
    output audio_pkg::tap_idx_t  coef_tap,
    output audio_pkg::coef_t     coef_data,
    output logic                 gain_we,
    output audio_pkg::coef_t     gain_data
);
    import audio_pkg::*;

    logic [7:0] ctrl;
    logic [7:0] select;
    logic [7:0] coef_lsb;
    logic [7:0] coef_msb;
    logic [7:0] gain_lsb;
    logic [7:0] gain_msb;
    tap_idx_t   coef_ptr;       // next tap to be written
    logic       wr_req;

    assign wr_req = wb_cyc & wb_stb & wb_we & ~wb_ack;   // once per cycle

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            ctrl     <= '0;
            select   <= '0;
            coef_lsb <= '0;
            coef_msb <= '0;
            gain_lsb <= '0;
            gain_msb <= '0;
            coef_ptr <= '0;
            coef_tap <= '0;
            coef_we  <= 1'b0;
            gain_we  <= 1'b0;
        end else begin
            wb_ack  <= wb_cyc & wb_stb & ~wb_ack;   // single beat, no waits
            coef_we <= 1'b0;
            gain_we <= 1'b0;
            if (wr_req) begin
                case (wb_adr)
                    REG_CTRL:     ctrl <= wb_dat_i;
                    REG_SELECT: begin
                        select   <= wb_dat_i;
                        coef_ptr <= '0;             // restart tap walk
                    end
                    REG_COEF_LSB: coef_lsb <= wb_dat_i;
                    REG_COEF_MSB: begin
                        coef_msb <= wb_dat_i;
                        coef_we  <= 1'b1;
                        coef_tap <= coef_ptr;
                        coef_ptr <= (coef_ptr == tap_idx_t'(TAPS - 1)) ? '0 : coef_ptr + 1'b1;
                    end
                    REG_GAIN_LSB: gain_lsb <= wb_dat_i;
                    REG_GAIN_MSB: begin
                        gain_msb <= wb_dat_i;
                        gain_we  <= 1'b1;
                    end
                    default: ;                      // status is read only
                endcase
            end
        end
    end

    // read mux, master holds adr through ack
    always_comb begin
        case (wb_adr)
            REG_CTRL:     wb_dat_o = ctrl;
            REG_SELECT:   wb_dat_o = select;
            REG_COEF_LSB: wb_dat_o = coef_lsb;
            REG_COEF_MSB: wb_dat_o = coef_msb;
            REG_GAIN_LSB: wb_dat_o = gain_lsb;
            REG_GAIN_MSB: wb_dat_o = gain_msb;
            REG_STATUS: begin
                wb_dat_o = 8'h00;
                wb_dat_o[STAT_COEF_PTR_ZERO] = (coef_ptr == '0);
            end
            default:      wb_dat_o = 8'h00;
        endcase
    end

    assign enable     = ctrl[CTRL_ENABLE];
    assign fir_bypass = ctrl[CTRL_FIR_BYPASS];
    // fir bypass skips the gains as well so band 0 reaches the dac exactly
    assign eq_bypass  = ctrl[CTRL_EQ_BYPASS] | ctrl[CTRL_FIR_BYPASS];
    assign band_sel   = select[BAND_W-1:0];
    assign coef_data  = {coef_msb, coef_lsb};
    assign gain_data  = {gain_msb, gain_lsb};

endmodule

//--- rtl/i2s_rx.sv
`timescale 1ns/1ps

module i2s_rx (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  enable,
    input  logic  bclk,
    input  logic  lrclk,
    input  logic  sd,
    pcm_if.source out
);
    import audio_pkg::*;

    logic [1:0]          bclk_sync;
    logic [1:0]          lrclk_sync;
    logic [1:0]          sd_sync;
    logic                bclk_q;
    logic                bclk_rise;
    logic                ws_q;          // word select at the previous rise
    logic [SLOT_W-1:0]   pos;           // bit position since the ws edge
    logic [SAMPLE_W-1:0] shreg;
    logic [SAMPLE_W-1:0] word;
    sample_t             left_q;
    logic                have_left;     // left word done while enabled
    logic                first_pend;
    logic                last_bit;
    logic                emit;

    assign bclk_rise = bclk_sync[1] & ~bclk_q;
    assign word      = {shreg[SAMPLE_W-2:0], sd_sync[1]};
    // 24th data bit of a slot, same channel as the rise before
    assign last_bit  = bclk_rise & enable & (lrclk_sync[1] == ws_q)
                     & (pos == SLOT_W'(SAMPLE_W - 1));
    assign emit      = last_bit & ws_q & have_left;     // right word closes the pair

    ////////////////////////////////////////
    // sync, edge detect and framing
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            sd_sync    <= '0;
            bclk_q     <= 1'b0;
            ws_q       <= 1'b0;
            pos        <= SLOT_W'(SLOT_BITS - 1);   // idle until a ws edge
            have_left  <= 1'b0;
            first_pend <= 1'b1;
            out.valid  <= 1'b0;
            out.first  <= 1'b0;
        end else begin
            bclk_sync  <= {bclk_sync[0], bclk};
            lrclk_sync <= {lrclk_sync[0], lrclk};
            sd_sync    <= {sd_sync[0], sd};
            bclk_q     <= bclk_sync[1];
            if (bclk_rise) begin
                ws_q <= lrclk_sync[1];
                if (lrclk_sync[1] != ws_q)
                    pos <= '0;                      // msb comes on the next rise
                else if (pos != SLOT_W'(SLOT_BITS - 1))
                    pos <= pos + 1'b1;
            end
            if (out.valid && out.ready)
                out.valid <= 1'b0;
            if (last_bit && !ws_q)
                have_left <= 1'b1;
            if (emit) begin
                out.valid  <= 1'b1;                 // an unaccepted pair is lost
                out.first  <= first_pend;
                first_pend <= 1'b0;
            end
            if (!enable) begin
                have_left  <= 1'b0;
                first_pend <= 1'b1;
            end
        end
    end

    // sample shifter and pair hold
    always_ff @(posedge clk) begin
        if (bclk_rise)
            shreg <= word;
        if (last_bit && !ws_q)
            left_q <= word;
        if (emit) begin
            out.data.left  <= left_q;
            out.data.right <= word;
        end
    end

endmodule

//--- rtl/fir_bank.sv
`timescale 1ns/1ps

module fir_bank (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 fir_bypass,
    input  logic                 coef_we,
    input  audio_pkg::band_idx_t band_sel,
    input  audio_pkg::tap_idx_t  coef_tap,
    input  audio_pkg::coef_t     coef_data,
    pcm_if.sink                  in,
    pcm_if.source                out
);
    import audio_pkg::*;

    coef_t                             coef_mem [NUM_BANDS][TAPS];
    sample_t                           hist_l [TAPS];      // [0] newest
    sample_t                           hist_r [TAPS];
    logic                              busy;
    logic [STEP_W-1:0]                 step;
    logic                              chan;               // 1 for right
    band_idx_t                         band;
    tap_idx_t                          tap;
    sample_t                           tap_smp;
    logic signed [COEF_W+SAMPLE_W-1:0] prod;
    acc_t                              acc;
    acc_t                              acc_nx;
    logic                              take;

    assign in.ready = ~busy & ~out.valid;
    assign take     = in.valid & in.ready;

    // step order is tap, then band, then channel
    assign tap  = tap_idx_t'(step % TAPS);
    assign band = band_idx_t'(step / TAPS);
    assign chan = (step >= STEP_W'(NUM_BANDS * TAPS));

    ////////////////////////////////////////
    // shared multiplier
    ////////////////////////////////////////
    always_comb begin
        tap_smp = chan ? hist_r[tap] : hist_l[tap];
        prod    = coef_mem[band][tap] * tap_smp;
        acc_nx  = (tap == '0) ? acc_t'(prod) : acc + acc_t'(prod);
    end

    always_ff @(posedge clk) begin
        if (coef_we)
            coef_mem[band_sel][coef_tap] <= coef_data;
    end

    // history, band results and bypass payload
    always_ff @(posedge clk) begin
        acc <= acc_nx;
        if (take) begin
            for (int t = 1; t < TAPS; t++) begin
                hist_l[t] <= in.first ? '0 : hist_l[t-1];   // fresh start after enable
                hist_r[t] <= in.first ? '0 : hist_r[t-1];
            end
            hist_l[0] <= in.data.left;
            hist_r[0] <= in.data.right;
            out.first <= in.first;
            if (fir_bypass) begin
                out.data          <= '0;
                out.data.left[0]  <= in.data.left;
                out.data.right[0] <= in.data.right;
            end
        end else if (busy && tap == tap_idx_t'(TAPS - 1)) begin
            if (chan)
                out.data.right[band] <= sat_sample(acc_nx >>> FRAC_W);
            else
                out.data.left[band] <= sat_sample(acc_nx >>> FRAC_W);
        end
    end

    ////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            step      <= '0;
            out.valid <= 1'b0;
        end else begin
            if (out.valid && out.ready)
                out.valid <= 1'b0;
            if (take) begin
                busy      <= ~fir_bypass;           // bypass is ready at once
                out.valid <= fir_bypass;
                step      <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == STEP_W'(MAC_STEPS - 1)) begin
                    busy      <= 1'b0;
                    out.valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/eq_mixer.sv
`timescale 1ns/1ps

module eq_mixer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 eq_bypass,
    input  logic                 gain_we,
    input  audio_pkg::band_idx_t band_sel,
    input  audio_pkg::coef_t     gain_data,
    pcm_if.sink                  in,
    output logic                 pair_valid,
    output audio_pkg::stereo_t   pair
);
    import audio_pkg::*;

    coef_t gain [NUM_BANDS];
    acc_t  wt_l [NUM_BANDS];    // weighted bands, q.15
    acc_t  wt_r [NUM_BANDS];
    logic  wt_valid;
    acc_t  sum_l;
    acc_t  sum_r;

    assign in.ready = 1'b1;     // pipe never stalls

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < NUM_BANDS; b++)
                gain[b] <= GAIN_INIT;
        end else if (gain_we) begin
            gain[band_sel] <= gain_data;
        end
    end

    ////////////////////////////////////////
    // stage 1, weighting
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            for (int b = 0; b < NUM_BANDS; b++) begin
                // bypass scales by exactly 1.0 so the shift below cancels
                wt_l[b] <= eq_bypass ? acc_t'(in.data.left[b]) <<< FRAC_W
                                     : acc_t'(gain[b]) * acc_t'(in.data.left[b]);
                wt_r[b] <= eq_bypass ? acc_t'(in.data.right[b]) <<< FRAC_W
                                     : acc_t'(gain[b]) * acc_t'(in.data.right[b]);
            end
        end
    end

    // stage 2, band sum and clamp
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int b = 0; b < NUM_BANDS; b++) begin
            sum_l = sum_l + wt_l[b];
            sum_r = sum_r + wt_r[b];
        end
    end

    always_ff @(posedge clk) begin
        if (wt_valid) begin
            pair.left  <= sat_sample(sum_l >>> FRAC_W);
            pair.right <= sat_sample(sum_r >>> FRAC_W);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wt_valid   <= 1'b0;
            pair_valid <= 1'b0;
        end else begin
            wt_valid   <= in.valid & in.ready;
            pair_valid <= wt_valid;                 // one cycle strobe
        end
    end

endmodule

//--- rtl/i2s_tx.sv
`timescale 1ns/1ps

module i2s_tx (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               enable,
    input  logic               bclk,
    input  logic               lrclk,
    input  logic               pair_valid,
    input  audio_pkg::stereo_t pair,
    output logic               dac_bclk,
    output logic               dac_lrclk,
    output logic               dac_data
);
    import audio_pkg::*;

    logic [1:0]          bclk_sync;
    logic [1:0]          lrclk_sync;
    logic                bclk_fall;
    logic                ws_edge;
    stereo_t             pend;          // newest processed pair
    logic                pend_vld;
    sample_t             right_q;       // right word of the frame on air
    logic [SAMPLE_W-1:0] shreg;

    // dac_bclk drops on this edge, data changes with it
    assign bclk_fall = dac_bclk & ~bclk_sync[1];
    assign ws_edge   = lrclk_sync[1] != dac_lrclk;

    always_ff @(posedge clk) begin
        if (pair_valid)
            pend <= pair;
    end

    ////////////////////////////////////////
    // dac clocks and serializer
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            dac_bclk   <= 1'b0;
            dac_lrclk  <= 1'b0;
            dac_data   <= 1'b0;
            pend_vld   <= 1'b0;
            right_q    <= '0;
            shreg      <= '0;
        end else begin
            bclk_sync  <= {bclk_sync[0], bclk};
            lrclk_sync <= {lrclk_sync[0], lrclk};
            dac_bclk   <= bclk_sync[1];
            dac_lrclk  <= lrclk_sync[1];
            if (bclk_fall) begin
                if (ws_edge) begin
                    dac_data <= 1'b0;               // pad bit of the old slot
                    if (!lrclk_sync[1]) begin       // new frame, left first
                        shreg    <= (enable && pend_vld) ? pend.left : '0;
                        right_q  <= (enable && pend_vld) ? pend.right : '0;
                        pend_vld <= 1'b0;
                    end else begin
                        shreg <= right_q;
                    end
                end else begin
                    dac_data <= shreg[SAMPLE_W-1];  // msb first, zeros after bit 24
                    shreg    <= shreg << 1;
                end
            end
            if (pair_valid)
                pend_vld <= 1'b1;
        end
    end

endmodule

//--- rtl/audio_processing.sv
`timescale 1ns/1ps

module audio_processing (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [2:0] wb_adr,
    input  logic [7:0] wb_dat_i,
    output logic [7:0] wb_dat_o,
    output logic       wb_ack,
    input  logic       i2s_bclk,
    input  logic       i2s_lrclk,
    input  logic       i2s_d,
    output logic       dac_bclk,
    output logic       dac_lrclk,
    output logic       dac_data
);
    import audio_pkg::*;

    // control from the register file
    logic      fir_bypass;
    logic      eq_bypass;
    logic      enable;
    band_idx_t band_sel;
    logic      coef_we;
    tap_idx_t  coef_tap;
    coef_t     coef_data;
    logic      gain_we;
    coef_t     gain_data;

    // mixer result to the dac side
    logic      pair_valid;
    stereo_t   pair;

    pcm_if #(.T(stereo_t))       rx_stream ();
    pcm_if #(.T(stereo_bands_t)) band_stream ();

    wb_audio_regs u_wb_audio_regs (.*);

    i2s_rx u_i2s_rx (
        .bclk  (i2s_bclk),
        .lrclk (i2s_lrclk),
        .sd    (i2s_d),
        .out   (rx_stream),
        .*
    );

    fir_bank u_fir_bank (
        .in  (rx_stream),
        .out (band_stream),
        .*
    );

    eq_mixer u_eq_mixer (
        .in (band_stream),
        .*
    );

    i2s_tx u_i2s_tx (
        .bclk  (i2s_bclk),
        .lrclk (i2s_lrclk),
        .*
    );

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;                          // held from time zero
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- test/audio_tb.sv
`timescale 1ns/1ps

module audio_tb;
    import audio_pkg::*;

    localparam int WB_TIMEOUT    = 16;
    localparam int FRAME_TIMEOUT = 2000;        // clk cycles, about four frames
    localparam int SYNC_TIMEOUT  = 1000;
    localparam logic [7:0] BIT_FIR = 8'h01 << CTRL_FIR_BYPASS;
    localparam logic [7:0] BIT_EQ  = 8'h01 << CTRL_EQ_BYPASS;
    localparam logic [7:0] BIT_EN  = 8'h01 << CTRL_ENABLE;

    logic       clk;
    logic       arst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [2:0] wb_adr;
    logic [7:0] wb_dat_i;
    logic [7:0] wb_dat_o;
    logic       wb_ack;
    logic       i2s_bclk  = 1'b0;
    logic       i2s_lrclk = 1'b0;
    logic       i2s_d     = 1'b0;
    logic       dac_bclk;
    logic       dac_lrclk;
    logic       dac_data;

    // i2s master
    logic [1:0]  div       = 2'd0;          // 4 clk per bclk half
    logic [5:0]  bit_idx   = 6'd63;         // first fall opens frame 0
    int          cur_frame = -1;
    stereo_t     cur_pair  = '0;
    logic [31:0] rng_i2s   = 32'd7;
    logic        loud      = 1'b0;          // near full scale samples
    stereo_t     sent [int];                // input pair per frame

    // dac decoder
    logic                dac_bclk_q    = 1'b0;
    logic                dac_ws_q      = 1'b0;
    logic [5:0]          dac_pos       = 6'd63;
    logic [SAMPLE_W-1:0] dac_shift     = '0;
    sample_t             dac_left      = '0;
    logic                dac_have_left = 1'b0;
    int                  dac_tag       = 0;  // input frame running at dac frame start
    stereo_t             dac_pairs [$];
    int                  dac_tags [$];

    // reference model state
    coef_t       coefs [NUM_BANDS][TAPS];
    coef_t       gains [NUM_BANDS];
    int          first_frame    = 0;         // first pair after enable
    bit          mdl_fir_bypass = 1'b0;
    bit          mdl_eq_bypass  = 1'b0;
    logic [31:0] rng_main       = 32'd7;

    tb_clk_gen u_tb_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    audio_processing u_audio_processing (.*);

    ////////////////////////////////////////
    // helpers and reference model
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic sample_t make_sample(input logic [31:0] r, input logic big);
        if (big)
            return {r[23], {15{~r[23]}}, r[7:0]};     // 0x7fffxx or 0x8000xx
        return r[23:0];
    endfunction

    function automatic sample_t clamp24(input longint v);
        if (v > 64'sd8388607)
            return 24'sh7FFFFF;
        else if (v < -64'sd8388608)
            return 24'sh800000;
        return sample_t'(v);
    endfunction

    // one channel of input frame k through fir and gains
    function automatic sample_t model_chan(input int k, input bit right);
        longint acc;
        longint mix;
        longint x;
        mix = 0;
        if (mdl_fir_bypass)
            return right ? sent[k].right : sent[k].left;
        for (int b = 0; b < NUM_BANDS; b++) begin
            acc = 0;
            for (int i = 0; i < TAPS; i++) begin
                x = 0;                              // history cleared before first pair
                if (k - i >= first_frame)
                    x = right ? sent[k-i].right : sent[k-i].left;
                acc += longint'(coefs[b][i]) * x;
            end
            acc = longint'(clamp24(acc >>> 15));    // band output
            mix += mdl_eq_bypass ? acc : longint'(gains[b]) * acc;
        end
        return mdl_eq_bypass ? clamp24(mix) : clamp24(mix >>> 15);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pair(input string name, input stereo_t got, input stereo_t want);
        if (got !== want)
            abort_run($sformatf("mismatch %s got 0x%012h expected 0x%012h", name, got, want));
    endtask

    task automatic check_reg(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want)
            abort_run($sformatf("mismatch %s got 0x%02h expected 0x%02h", name, got, want));
    endtask

    ////////////////////////////////////////
    // wishbone master and waits
    ////////////////////////////////////////
    task automatic wb_cycle(input logic [2:0] adr, input logic we, input logic [7:0] dat,
                            output logic [7:0] rd);
        int n;
        n = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= dat;
        do begin
            @(posedge clk);
            n++;
            if (n > WB_TIMEOUT)
                abort_run($sformatf("no wishbone ack for register %0d", adr));
        end while (wb_ack !== 1'b1);
        rd = wb_dat_o;                              // adr still held here
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wb_cycle(adr, 1'b1, dat, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [7:0] rd);
        wb_cycle(adr, 1'b0, 8'h00, rd);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 100)
                abort_run("reset was never released");
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > SYNC_TIMEOUT)
                abort_run("i2s master never started a frame");
        end while (bit_idx != 6'd0);
    endtask

    task automatic next_dac_frame(output stereo_t p, output int tag);
        int n;
        n = 0;
        while (dac_pairs.size() == 0) begin
            @(posedge clk);
            n++;
            if (n > FRAME_TIMEOUT)
                abort_run("no dac frame arrived in time");
        end
        p   = dac_pairs.pop_front();
        tag = dac_tags.pop_front();
    endtask

    // dac frame t carries input frame t-1
    task automatic check_frames(input int after_tag, input int count, input bit zero);
        stereo_t got;
        stereo_t want;
        int      tag;
        int      seen;
        seen = 0;
        while (seen < count) begin
            next_dac_frame(got, tag);
            if (tag > after_tag) begin
                want.left  = zero ? '0 : model_chan(tag - 1, 1'b0);
                want.right = zero ? '0 : model_chan(tag - 1, 1'b1);
                check_pair($sformatf("dac_data pair of frame %0d", tag), got, want);
                seen++;
            end
        end
    endtask

    task automatic start_stream(input logic [7:0] ctrl);
        wait_frame_start();
        first_frame = cur_frame;                    // its left word is still ahead
        wb_write(REG_CTRL, ctrl);
    endtask

    task automatic load_coefs(input int shift);
        coef_t c;
        for (int b = 0; b < NUM_BANDS; b++) begin
            wb_write(REG_SELECT, 8'(b));            // tap pointer back to 0
            for (int i = 0; i < TAPS; i++) begin
                rng_main = xorshift32(rng_main);
                c = coef_t'(rng_main[15:0]) >>> shift;
                coefs[b][i] = c;
                wb_write(REG_COEF_LSB, c[7:0]);
                wb_write(REG_COEF_MSB, c[15:8]);
            end
        end
    endtask

    task automatic load_gains();
        coef_t g;
        for (int b = 0; b < NUM_BANDS; b++) begin
            rng_main = xorshift32(rng_main);
            g = coef_t'(rng_main[15:0]);
            gains[b] = g;
            wb_write(REG_SELECT, 8'(b));
            wb_write(REG_GAIN_LSB, g[7:0]);
            wb_write(REG_GAIN_MSB, g[15:8]);
        end
    endtask

    task automatic reg_test();
        logic [7:0] v;
        logic [7:0] rd;
        for (int i = 0; i < 8; i++) begin
            rng_main = xorshift32(rng_main);
            v = rng_main[7:0];
            wb_write(REG_CTRL, v);
            wb_read(REG_CTRL, rd);
            check_reg("wb_dat_o ctrl", rd, v);
            v = rng_main[15:8];
            wb_write(REG_SELECT, v);
            wb_read(REG_SELECT, rd);
            check_reg("wb_dat_o select", rd, v);
        end
        wb_write(REG_COEF_MSB, 8'h00);              // pointer off tap 0
        wb_read(REG_STATUS, rd);
        check_reg("wb_dat_o status", rd, 8'h00);
        wb_write(REG_SELECT, 8'h00);
        wb_read(REG_STATUS, rd);
        check_reg("wb_dat_o status", rd, 8'h01);
        for (int i = 0; i < TAPS; i++) begin
            wb_write(REG_COEF_MSB, 8'h00);
            wb_read(REG_STATUS, rd);
            check_reg("wb_dat_o status", rd, (i == TAPS - 1) ? 8'h01 : 8'h00);
        end
    endtask

    ////////////////////////////////////////
    // i2s source and dac decoder
    ////////////////////////////////////////
    always @(posedge clk) begin : i2s_master
        logic [5:0]  nxt;
        logic [31:0] r1;
        logic [31:0] r2;
        stereo_t     pr;
        sample_t     s;
        int          p;
        div <= div + 2'd1;
        if (div == 2'd3) begin
            i2s_bclk <= ~i2s_bclk;
            if (i2s_bclk) begin                     // bclk falls, ws and data move
                nxt = bit_idx + 6'd1;
                pr  = cur_pair;
                if (nxt == 6'd0) begin              // new frame, new pair
                    r1 = xorshift32(rng_i2s);
                    r2 = xorshift32(r1);
                    pr.left  = make_sample(r1, loud);
                    pr.right = make_sample(r2, loud);
                    sent[cur_frame + 1] = pr;
                    rng_i2s   <= r2;
                    cur_pair  <= pr;
                    cur_frame <= cur_frame + 1;
                end
                p = int'(nxt[4:0]);
                s = nxt[5] ? pr.right : pr.left;
                bit_idx   <= nxt;
                i2s_lrclk <= nxt[5];                // low is left
                i2s_d     <= (p >= 1 && p <= SAMPLE_W) ? s[SAMPLE_W - p] : 1'b0;
            end
        end
    end

    always @(posedge clk) begin : dac_decoder
        logic [SAMPLE_W-1:0] word;
        stereo_t             fr;
        dac_bclk_q <= dac_bclk;
        if (dac_bclk && !dac_bclk_q) begin
            dac_ws_q <= dac_lrclk;
            word = {dac_shift[SAMPLE_W-2:0], dac_data};
            if (dac_lrclk != dac_ws_q) begin
                dac_pos <= 6'd0;                    // pad bit, msb next
                if (!dac_lrclk)
                    dac_tag <= cur_frame;
            end else begin
                if (dac_pos != 6'd63)
                    dac_pos <= dac_pos + 6'd1;
                if (dac_pos < 6'(SAMPLE_W))
                    dac_shift <= word;
                if (dac_pos == 6'(SAMPLE_W - 1)) begin
                    if (!dac_lrclk) begin
                        dac_left      <= word;
                        dac_have_left <= 1'b1;
                    end else if (dac_have_left) begin
                        fr.left  = dac_left;
                        fr.right = word;
                        dac_pairs.push_back(fr);
                        dac_tags.push_back(dac_tag);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin : main
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 3'd0;
        wb_dat_i = 8'h00;
        for (int b = 0; b < NUM_BANDS; b++)
            gains[b] = GAIN_INIT;
        wait_reset();

        reg_test();

        // sample bypass, output equals input one frame later
        mdl_fir_bypass = 1'b1;
        mdl_eq_bypass  = 1'b1;
        start_stream(BIT_EN | BIT_FIR);
        check_frames(first_frame, 8, 1'b0);

        // enable low, dac stays silent
        wb_write(REG_CTRL, BIT_FIR);
        check_frames(cur_frame, 4, 1'b1);

        // fir bands summed without gains
        wb_write(REG_CTRL, 8'h00);
        load_coefs(2);
        mdl_fir_bypass = 1'b0;
        mdl_eq_bypass  = 1'b1;
        start_stream(BIT_EN | BIT_EQ);
        check_frames(first_frame, 8, 1'b0);

        // full path, then loud input for saturation
        wb_write(REG_CTRL, 8'h00);
        load_coefs(1);
        load_gains();
        mdl_eq_bypass = 1'b0;
        start_stream(BIT_EN);
        check_frames(first_frame, 6, 1'b0);
        loud <= 1'b1;
        check_frames(first_frame, 8, 1'b0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- list.f
rtl/audio_pkg.sv
rtl/pcm_if.sv
rtl/wb_audio_regs.sv
rtl/i2s_rx.sv
rtl/fir_bank.sv
rtl/eq_mixer.sv
rtl/i2s_tx.sv
rtl/audio_processing.sv
test/tb_clk_gen.sv
test/audio_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then scan the simulation log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module audio_tb \
    -f list.f -o audio_sim > build.log 2>&1 \
    && ./obj_dir/audio_sim > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
test -s sim.log && ! grep -qF '*** TEST FAILED ***' sim.log && echo "run clean" || exit 1
